//--- all.f
common/mmu_cfg_pkg.sv
common/mmu_ctrl_pkg.sv
control/multip_control.sv
logic/weight_loader.sv
logic/data_feeder.sv
systolic_array/systolic_array.sv
logic/accum_table.sv
logic/matmul_top.sv
verification/matmul_tb.sv

//--- Bender.yml
package:
  name: matmul_unit

sources:
  - files:
      - common/mmu_cfg_pkg.sv
      - common/mmu_ctrl_pkg.sv
      - control/multip_control.sv
      - logic/weight_loader.sv
      - logic/data_feeder.sv
      - systolic_array/systolic_array.sv
      - logic/accum_table.sv
      - logic/matmul_top.sv

  - target: test
    files:
      - verification/matmul_tb.sv

//--- verification/matmul_tb.sv
module matmul_tb import mmu_cfg_pkg::*, mmu_ctrl_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int job_cycles     = 40;   // Cycle budget per job
  localparam int clear_cycles   = 200;  // Cycle budget per clear sweep
  localparam int timeout_cycles = 40 * job_cycles + 3 * clear_cycles;

  logic         clk = 1'b0;
  logic         reset;
  logic         start;
  job_t         job_in;
  logic         weight_wr;
  row_addr_t    weight_addr;
  operand_row_t weight_row;
  logic         data_wr;
  row_addr_t    data_addr;
  operand_row_t data_row;
  logic         clear;
  row_addr_t    rd_row;
  col_idx_t     rd_col;
  acc_t         rd_data;
  logic         fifo_ready;
  logic         done;

  operand_row_t w_mat [arr_dim];
  operand_row_t d_mat [max_rows];
  acc_t         shadow [tile_rows][tile_cols][max_rows][arr_dim];  // Expected table
  job_t         cur_job;                                            // Tile seen by the read port
  logic [31:0]  rng = 32'hfaf1_ba02;
  string        test_name;
  logic         check_en;
  acc_t         exp_val;
  int           err_cnt = 0;
  int           err_mark = 0;
  int           pass_cnt = 0;
  int           fail_cnt = 0;
  int           cycles = 0;

  matmul_top dut_i (.*);

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= timeout_cycles) begin
      $display("Timeout: run exceeded %0d cycles without finishing", timeout_cycles);
      $display("Simulation failed");
      $finish;
    end
  end

  // ----------------------------------------
  // Checkers
  // ----------------------------------------
  assert property (@(posedge clk) disable iff (reset) check_en |-> rd_data == exp_val)
    else begin
      $display("CHECK FAILED %s: row %0d col %0d expected %0d actual %0d", test_name,
               $sampled(rd_row), $sampled(rd_col), $sampled(exp_val), $sampled(rd_data));
      err_cnt++;
    end

  assert property (@(posedge clk) disable iff (reset) done |-> fifo_ready)
    else begin
      $display("fifo_ready was low while done was high in test %s", test_name);
      err_cnt++;
    end

  assert property (@(posedge clk) disable iff (reset) (start || clear) && done |=> !done)
    else begin
      $display("done stayed high after an accepted start or clear in test %s", test_name);
      err_cnt++;
    end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
  endfunction

  function automatic logic [31:0] next_rand();
    rng = xorshift(rng);
    return rng;
  endfunction

  function automatic job_t make_job(input int k, input int ncol, input int nrow,
                                    input int tr, input int tc);
    return '{dim_t'(k), dim_t'(ncol), row_cnt_t'(nrow), tile_row_t'(tr), tile_col_t'(tc)};
  endfunction

  task automatic randomize_operands();
    foreach (w_mat[k]) w_mat[k] = next_rand();  // Four bytes fill one row
    foreach (d_mat[r]) d_mat[r] = next_rand();
  endtask

  task automatic load_memories();
    for (int r = 0; r < max_rows; r++) begin
      @(negedge clk);
      data_wr     = 1'b1;
      data_addr   = row_addr_t'(r);
      data_row    = d_mat[r];
      weight_wr   = (r < arr_dim);
      weight_addr = row_addr_t'(r);
      weight_row  = w_mat[r % arr_dim];
    end
    @(negedge clk);
    data_wr   = 1'b0;
    weight_wr = 1'b0;
  endtask

  // Entry (r, c) gains the dot product of data row r and weight column c
  task automatic add_product(input job_t j);
    acc_t sum;
    for (int r = 0; r < j.num_row_data; r++) begin
      for (int c = 0; c < j.num_col_weight; c++) begin
        sum = '0;
        for (int k = 0; k < j.intermed_dim; k++) begin
          sum += acc_t'(d_mat[r][k]) * acc_t'(w_mat[k][c]);
        end
        shadow[j.submat_row][j.submat_col][r][c] += sum;
      end
    end
  endtask

  task automatic run_job(input job_t j, input bit poke, input job_t poke_job);
    bit saw_busy;
    add_product(j);
    cur_job = j;
    @(negedge clk);
    start  = 1'b1;
    job_in = j;
    @(negedge clk);
    start    = 1'b0;
    saw_busy = !fifo_ready;  // Weight load runs right after the accepting edge
    if (poke) begin
      start  = 1'b1;         // Controller is busy here
      job_in = poke_job;
      @(negedge clk);
      start = 1'b0;
    end
    while (!done) begin
      saw_busy |= !fifo_ready;
      @(negedge clk);
    end
    assert (saw_busy) else begin
      $display("fifo_ready never dropped during a job in test %s", test_name);
      err_cnt++;
    end
  endtask

  task automatic read_tile();
    for (int r = 0; r < max_rows; r++) begin
      for (int c = 0; c < arr_dim; c++) begin
        @(negedge clk);
        rd_row   = row_addr_t'(r);
        rd_col   = col_idx_t'(c);
        exp_val  = shadow[cur_job.submat_row][cur_job.submat_col][r][c];
        check_en = 1'b1;
      end
    end
    @(negedge clk);
    check_en = 1'b0;
  endtask

  // Zero data row adds nothing and only moves the read port
  task automatic probe_tile(input int tr, input int tc);
    d_mat[0] = '0;
    load_memories();
    run_job(make_job(1, 1, 1, tr, tc), 1'b0, '0);
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    err_mark  = err_cnt;
  endtask

  task automatic end_test();
    if (err_cnt == err_mark) begin
      pass_cnt++;
      $display("test %s: passed", test_name);
    end else begin
      fail_cnt++;
      $display("test %s: failed", test_name);
    end
  endtask

  // ----------------------------------------
  // Test sequence
  // ----------------------------------------
  initial begin
    int low_cycles;
    reset       = 1'b1;
    start       = 1'b0;
    job_in      = '0;
    weight_wr   = 1'b0;
    weight_addr = '0;
    weight_row  = '0;
    data_wr     = 1'b0;
    data_addr   = '0;
    data_row    = '0;
    clear       = 1'b0;
    rd_row      = '0;
    rd_col      = '0;
    check_en    = 1'b0;
    exp_val     = '0;
    cur_job     = '0;
    shadow      = '{default: '0};
    repeat (3) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    begin_test("reset_state");
    assert (done && fifo_ready) else begin
      $display("done or fifo_ready was low after reset");
      err_cnt++;
    end
    read_tile();  // Read port starts on tile (0, 0)
    end_test();

    begin_test("full_size");
    randomize_operands();
    load_memories();
    run_job(make_job(4, 4, 8, 1, 2), 1'b0, '0);
    read_tile();
    end_test();

    begin_test("reduced_dims");
    repeat (5) begin
      randomize_operands();
      load_memories();
      run_job(make_job(1 + next_rand() % 3, 1 + next_rand() % 3, 1 + next_rand() % 7,
                       next_rand() % 4, next_rand() % 4), 1'b0, '0);
      read_tile();
    end
    end_test();

    begin_test("accumulate");
    randomize_operands();
    load_memories();
    run_job(make_job(4, 4, 8, 2, 1), 1'b0, '0);
    randomize_operands();
    load_memories();
    run_job(make_job(3, 4, 6, 2, 1), 1'b0, '0);
    read_tile();
    randomize_operands();
    load_memories();
    run_job(make_job(4, 4, 8, 3, 3), 1'b0, '0);
    probe_tile(2, 1);
    read_tile();
    end_test();

    begin_test("ignored_start");
    randomize_operands();
    load_memories();
    run_job(make_job(2, 3, 5, 0, 3), 1'b1, make_job(4, 4, 8, 1, 0));
    repeat (4) @(negedge clk);
    assert (done) else begin
      $display("a start given while busy launched a second job");
      err_cnt++;
    end
    read_tile();
    end_test();

    begin_test("clear");
    @(negedge clk);
    clear = 1'b1;
    @(negedge clk);
    clear      = 1'b0;
    low_cycles = 0;
    while (!done) begin
      low_cycles++;
      @(negedge clk);
    end
    assert (low_cycles == tbl_depth) else begin
      $display("CHECK FAILED %s: busy cycles expected %0d actual %0d",
               test_name, tbl_depth, low_cycles);
      err_cnt++;
    end
    shadow = '{default: '0};
    for (int tr = 0; tr < tile_rows; tr++) begin
      for (int tc = 0; tc < tile_cols; tc++) begin
        probe_tile(tr, tc);
        read_tile();
      end
    end
    end_test();

    $display("tests passed %0d failed %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0 && err_cnt == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- logic/matmul_top.sv
module matmul_top import mmu_cfg_pkg::*, mmu_ctrl_pkg::*; (
  input  logic         clk,
  input  logic         reset,
  input  logic         start,
  input  job_t         job_in,
  input  logic         weight_wr,
  input  row_addr_t    weight_addr,
  input  operand_row_t weight_row,
  input  logic         data_wr,
  input  row_addr_t    data_addr,
  input  operand_row_t data_row,
  input  logic         clear,
  input  row_addr_t    rd_row,
  input  col_idx_t     rd_col,
  output acc_t         rd_data,
  output logic         fifo_ready,
  output logic         done
);

  job_t         job;
  logic         weight_en, weight_done;
  logic         calc_en, calc_done;
  logic         clear_busy;
  logic         w_shift;
  operand_row_t w_in;
  operand_row_t a_in;
  logic         a_valid;
  acc_row_t     col_out;
  logic         out_valid;

  multip_control u_ctrl (
    .clk, .reset, .start, .job_in, .weight_done, .calc_done, .clear_busy,
    .job, .weight_en, .calc_en, .fifo_ready, .done
  );

  weight_loader u_wload (
    .clk, .reset, .weight_en, .job, .weight_wr, .weight_addr, .weight_row,
    .w_shift, .w_in, .weight_done
  );

  data_feeder u_dfeed (
    .clk, .reset, .calc_en, .job, .data_wr, .data_addr, .data_row,
    .a_in, .a_valid, .calc_done
  );

  systolic_array u_array (
    .clk, .reset, .w_shift, .w_in, .a_in, .a_valid, .col_out, .out_valid
  );

  accum_table u_table (
    .clk, .reset, .calc_en, .job, .col_out, .out_valid, .clear, .done,
    .rd_row, .rd_col, .rd_data, .clear_busy
  );

endmodule

//--- logic/accum_table.sv
module accum_table import mmu_cfg_pkg::*, mmu_ctrl_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  logic      calc_en,
  input  job_t      job,
  input  acc_row_t  col_out,
  input  logic      out_valid,
  input  logic      clear,
  input  logic      done,
  input  row_addr_t rd_row,
  input  col_idx_t  rd_col,
  output acc_t      rd_data,
  output logic      clear_busy
);

  acc_row_t  mem [tbl_depth];  // One entry per tile and data row
  row_cnt_t  out_row;
  tbl_addr_t wr_addr;
  tbl_addr_t rd_addr;
  tbl_addr_t clr_addr;

  assign wr_addr = {job.submat_row, job.submat_col, out_row[$bits(row_addr_t)-1:0]};
  assign rd_addr = {job.submat_row, job.submat_col, rd_row};
  assign rd_data = mem[rd_addr][rd_col];  // Same-cycle host read

  // Output row index, restarted with each calculation phase
  always_ff @(posedge clk) begin
    if (reset || !calc_en) begin
      out_row <= '0;
    end else if (out_valid) begin
      out_row <= out_row + 1'b1;
    end
  end

  // ----------------------------------------
  // Clear sweep
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      clear_busy <= 1'b0;
      clr_addr   <= '0;
    end else if (clear_busy) begin
      clr_addr <= clr_addr + 1'b1;
      if (clr_addr == tbl_addr_t'(tbl_depth - 1)) clear_busy <= 1'b0;
    end else if (clear && done) begin
      clear_busy <= 1'b1;
      clr_addr   <= '0;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < tbl_depth; i++) begin
        mem[i] <= '0;
      end
    end else if (clear_busy) begin
      mem[clr_addr] <= '0;
    end else if (out_valid) begin
      for (int j = 0; j < arr_dim; j++) begin
        if (j < job.num_col_weight) begin
          mem[wr_addr][j] <= mem[wr_addr][j] + col_out[j];
        end
      end
    end
  end

  // The array emits exactly one row per streamed data row
  assert property (@(posedge clk) disable iff (reset)
    out_valid |-> out_row < job.num_row_data);

endmodule

//--- systolic_array/systolic_array.sv
module systolic_array import mmu_cfg_pkg::*; (
  input  logic         clk,
  input  logic         reset,
  input  logic         w_shift,
  input  operand_row_t w_in,
  input  operand_row_t a_in,
  input  logic         a_valid,
  output acc_row_t     col_out,
  output logic         out_valid
);

  operand_t w_reg [arr_dim][arr_dim];  // Stationary weights, [row][col]
  operand_t a_reg [arr_dim][arr_dim];  // Data moving right
  acc_t     ps    [arr_dim][arr_dim];  // Partial sums moving down
  logic [out_latency-2:0] valid_sr;

  // ----------------------------------------
  // MAC cell grid
  // ----------------------------------------
  for (genvar r = 0; r < arr_dim; r++) begin : g_row
    for (genvar c = 0; c < arr_dim; c++) begin : g_col
      operand_t a_left;
      operand_t w_up;
      acc_t     ps_up;

      if (c == 0) begin : g_edge_a
        assign a_left = a_in[r];
      end else begin : g_int_a
        assign a_left = a_reg[r][c-1];
      end

      if (r == 0) begin : g_edge_w
        assign w_up  = w_in[c];
        assign ps_up = '0;           // Top row starts each sum
      end else begin : g_int_w
        assign w_up  = w_reg[r-1][c];
        assign ps_up = ps[r-1][c];
      end

      always_ff @(posedge clk) begin
        if (reset) begin
          w_reg[r][c] <= '0;
          a_reg[r][c] <= '0;
          ps[r][c]    <= '0;
        end else begin
          if (w_shift) begin
            w_reg[r][c] <= w_up;
          end
          a_reg[r][c] <= a_left;
          ps[r][c]    <= ps_up + a_left * w_reg[r][c];
        end
      end
    end
  end

  // ----------------------------------------
  // Output de-skew
  // ----------------------------------------
  for (genvar c = 0; c < arr_dim; c++) begin : g_deskew
    if (c == arr_dim - 1) begin : g_direct
      assign col_out[c] = ps[arr_dim-1][c];  // Last column is already the latest
    end else begin : g_dly
      acc_t dly [arr_dim-1-c];
      always_ff @(posedge clk) begin
        dly[0] <= ps[arr_dim-1][c];
        for (int s = 1; s < arr_dim - 1 - c; s++) begin
          dly[s] <= dly[s-1];
        end
      end
      assign col_out[c] = dly[arr_dim-2-c];
    end
  end

  // Valid follows the row through the grid and de-skew
  always_ff @(posedge clk) begin
    if (reset) begin
      valid_sr <= '0;
    end else begin
      valid_sr <= {valid_sr[out_latency-3:0], a_valid};
    end
  end

  assign out_valid = valid_sr[out_latency-2];

endmodule

//--- logic/data_feeder.sv
module data_feeder import mmu_cfg_pkg::*, mmu_ctrl_pkg::*; (
  input  logic         clk,
  input  logic         reset,
  input  logic         calc_en,
  input  job_t         job,
  input  logic         data_wr,
  input  row_addr_t    data_addr,
  input  operand_row_t data_row,
  output operand_row_t a_in,
  output logic         a_valid,
  output logic         calc_done
);

  operand_row_t mem [max_rows];  // Row r is data matrix row r
  logic [$clog2(max_rows+out_latency)-1:0] cnt;
  logic         feeding;
  row_addr_t    rd_addr;
  operand_row_t row_q;
  logic         valid_q;

  always_ff @(posedge clk) begin
    if (data_wr) begin
      mem[data_addr] <= data_row;
    end
  end

  // ----------------------------------------
  // Row streamer and drain counter
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (reset || !calc_en) begin
      cnt <= '0;
    end else begin
      cnt <= cnt + 1'b1;
    end
  end

  assign feeding   = calc_en && (cnt < job.num_row_data);
  assign rd_addr   = cnt[$bits(row_addr_t)-1:0];
  assign calc_done = calc_en && (cnt == job.num_row_data + (out_latency - 1));  // Last row out

  always_ff @(posedge clk) begin
    if (reset) begin
      row_q   <= '0;
      valid_q <= 1'b0;
    end else begin
      valid_q <= feeding;
      for (int k = 0; k < arr_dim; k++) begin
        row_q[k] <= (feeding && k < job.intermed_dim) ? mem[rd_addr][k] : '0;
      end
    end
  end

  // ----------------------------------------
  // Staircase skew where element k waits k cycles
  // ----------------------------------------
  assign a_in[0] = row_q[0];
  assign a_valid = valid_q;  // Aligned with element 0

  for (genvar k = 1; k < arr_dim; k++) begin : g_skew
    operand_t sk [k];
    always_ff @(posedge clk) begin
      if (reset) begin
        for (int s = 0; s < k; s++) begin
          sk[s] <= '0;
        end
      end else begin
        sk[0] <= row_q[k];
        for (int s = 1; s < k; s++) begin
          sk[s] <= sk[s-1];
        end
      end
    end
    assign a_in[k] = sk[k-1];
  end

  // Read address never wraps past the data memory, so it stays below the row count
  assert property (@(posedge clk) disable iff (reset)
    feeding |-> cnt < max_rows);

endmodule

//--- logic/weight_loader.sv
module weight_loader import mmu_cfg_pkg::*, mmu_ctrl_pkg::*; (
  input  logic         clk,
  input  logic         reset,
  input  logic         weight_en,
  input  job_t         job,
  input  logic         weight_wr,
  input  row_addr_t    weight_addr,
  input  operand_row_t weight_row,
  output logic         w_shift,
  output operand_row_t w_in,
  output logic         weight_done
);

  operand_row_t mem [arr_dim];  // Row k is weight matrix row k
  operand_row_t rd_row;
  dim_t         shift_cnt;
  dim_t         last_row;
  dim_t         rd_full;

  always_ff @(posedge clk) begin
    if (weight_wr) begin
      mem[weight_addr[arr_sel_w-1:0]] <= weight_row;
    end
  end

  // ----------------------------------------
  // Shift sequencer
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (reset || !weight_en) begin
      shift_cnt <= '0;
    end else begin
      shift_cnt <= shift_cnt + 1'b1;
    end
  end

  assign last_row = job.intermed_dim - 1'b1;
  assign rd_full  = last_row - shift_cnt;         // Highest row first, row 0 lands on top
  assign rd_row   = mem[rd_full[arr_sel_w-1:0]];

  always_comb begin
    for (int j = 0; j < arr_dim; j++) begin
      w_in[j] = (j < job.num_col_weight) ? rd_row[j] : '0;  // Unused columns carry zero
    end
  end

  assign w_shift     = weight_en;
  assign weight_done = weight_en && (shift_cnt == last_row);

  // No shift outside the load phase or past the inner dimension
  assert property (@(posedge clk) disable iff (reset)
    w_shift |-> weight_en && (shift_cnt < job.intermed_dim));

endmodule

//--- control/multip_control.sv
module multip_control import mmu_cfg_pkg::*, mmu_ctrl_pkg::*; (
  input  logic clk,
  input  logic reset,
  input  logic start,
  input  job_t job_in,
  input  logic weight_done,
  input  logic calc_done,
  input  logic clear_busy,
  output job_t job,
  output logic weight_en,
  output logic calc_en,
  output logic fifo_ready,
  output logic done
);

  ctrl_state_t state, state_c;
  logic        start_ok;

  assign start_ok = start && done;  // Start is ignored while busy

  // ----------------------------------------
  // State register and next state
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= hold;
    end else begin
      state <= state_c;
    end
  end

  always_comb begin
    state_c = state;
    case (state)
      hold: begin
        if (start_ok) state_c = w_fifo_arr;
      end
      w_fifo_arr: begin
        if (weight_done) state_c = d_mem_calc;
      end
      d_mem_calc: begin
        if (calc_done) state_c = hold;
      end
      default: state_c = hold;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      job <= '0;
    end else if (start_ok) begin
      job <= job_in;  // Held for the whole job and later host reads
    end
  end

  assign weight_en  = (state == w_fifo_arr);
  assign calc_en    = (state == d_mem_calc);
  assign fifo_ready = (state != w_fifo_arr);
  assign done       = (state == hold) && !clear_busy;

  // Phases are exclusive and weight_done only closes an open load
  assert property (@(posedge clk) disable iff (reset) !(weight_en && calc_en));
  assert property (@(posedge clk) disable iff (reset) weight_done |-> weight_en);
  assert property (@(posedge clk) disable iff (reset)
    start_ok |-> job_in.intermed_dim inside {[1:arr_dim]} &&
                 job_in.num_col_weight inside {[1:arr_dim]});

endmodule

//--- common/mmu_ctrl_pkg.sv
package mmu_ctrl_pkg;
  import mmu_cfg_pkg::*;

  // ----------------------------------------
  // Controller phases
  // ----------------------------------------
  typedef enum logic [1:0] {
    hold,        // Idle, done reported
    w_fifo_arr,  // Weight rows shift into the array
    d_mem_calc   // Data rows stream through the array
  } ctrl_state_t;

  // ----------------------------------------
  // Job descriptor
  // ----------------------------------------
  typedef struct packed {
    dim_t      intermed_dim;    // Inner dimension of the product
    dim_t      num_col_weight;  // Used weight columns
    row_cnt_t  num_row_data;    // Data rows to stream
    tile_row_t submat_row;      // Tile position in the table
    tile_col_t submat_col;
  } job_t;

endpackage

//--- common/mmu_cfg_pkg.sv
package mmu_cfg_pkg;

  // ----------------------------------------
  // Array and memory geometry
  // ----------------------------------------
  localparam int arr_dim     = 4;                    // Array side length
  localparam int max_rows    = 8;                    // Data memory depth
  localparam int tile_rows   = 4;                    // Tile positions along rows
  localparam int tile_cols   = 4;                    // Tile positions along columns
  localparam int operand_w   = 8;
  localparam int acc_w       = 20;
  localparam int arr_sel_w   = $clog2(arr_dim);
  localparam int out_latency = 2 * arr_dim;          // Data row read to output row
  localparam int tbl_depth   = tile_rows * tile_cols * max_rows;

  // ----------------------------------------
  // Vector types
  // ----------------------------------------
  typedef logic [operand_w-1:0] operand_t;           // Unsigned weight or data element
  typedef logic [acc_w-1:0] acc_t;
  typedef operand_t [arr_dim-1:0] operand_row_t;     // One memory row
  typedef acc_t [arr_dim-1:0] acc_row_t;
  typedef logic [$clog2(arr_dim+1)-1:0] dim_t;       // 1 to arr_dim
  typedef logic [$clog2(max_rows+1)-1:0] row_cnt_t;  // 1 to max_rows
  typedef logic [$clog2(max_rows)-1:0] row_addr_t;
  typedef logic [$clog2(tile_rows)-1:0] tile_row_t;
  typedef logic [$clog2(tile_cols)-1:0] tile_col_t;
  typedef logic [arr_sel_w-1:0] col_idx_t;           // Column within a tile
  typedef logic [$clog2(tbl_depth)-1:0] tbl_addr_t;  // Tile row, tile col, data row

endpackage
